/* hdl/video_pkg.sv */
`default_nettype none

package video_pkg;

	// 800x600 at 60 Hz, 40 MHz pixel clock
	localparam int H_ACTIVE = 800;
	localparam int H_FRONT = 40;
	localparam int H_SYNC = 128;
	localparam int H_BACK = 88;
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK; // 1056

	localparam int V_ACTIVE = 600;
	localparam int V_FRONT = 1;
	localparam int V_SYNC = 4;
	localparam int V_BACK = 23;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK; // 628

	localparam int CNT_W = 11;

	// bitmap, one row per line in the mem file
	localparam int IMG_W = 40;
	localparam int IMG_H = 30;
	localparam int IMG_BITS = IMG_W * IMG_H;
	localparam int IMG_COL_W = $clog2(IMG_W);
	localparam int IMG_ROW_W = $clog2(IMG_H);
	localparam string IMG_FILE = "hdl/heart_bitmap.mem";

	localparam int COLOR_W = 4;
	localparam int KEY_FIELD_W = 3;

	// one pixel slot as it moves down the chain
	typedef struct packed {
		logic [CNT_W-1:0] h_count;
		logic [CNT_W-1:0] v_count;
		logic h_sync;
		logic v_sync;
		logic display_en;
	} video_beat_t;

	typedef struct packed {
		logic [COLOR_W-1:0] r;
		logic [COLOR_W-1:0] g;
		logic [COLOR_W-1:0] b;
	} rgb_t;

endpackage

`default_nettype wire

/* hdl/adc_pkg.sv */
`default_nettype none

package adc_pkg;

	localparam int ADC_BITS = 15; // width of stored charge time
	localparam int ADC_DIV = 4; // clocks per sample tick
	localparam int ADC_DIV_W = $clog2(ADC_DIV);

	// top bit of the tick counter picks the phase
	typedef enum logic {
		CHARGE = 1'b0,
		DISCHARGE = 1'b1
	} adc_phase_t;

endpackage

`default_nettype wire

/* hdl/video_timing.sv */
`timescale 1ns/100ps
`default_nettype none

module video_timing
	import video_pkg::*;
(
	input wire clk_in,
	input wire arst_n,
	output video_beat_t beat
);

	logic [CNT_W-1:0] h_cnt;
	logic [CNT_W-1:0] v_cnt;
	logic h_last;
	logic v_last;

	assign h_last = (h_cnt == CNT_W'(H_TOTAL - 1));
	assign v_last = (v_cnt == CNT_W'(V_TOTAL - 1));

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else begin
			if (h_last) begin
				h_cnt <= '0;
				// next line on every horizontal wrap
				if (v_last) begin
					v_cnt <= '0;
				end else begin
					v_cnt <= v_cnt + 1'b1;
				end
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	// flags straight off the counters
	always_comb begin
		beat.h_count = h_cnt;
		beat.v_count = v_cnt;
		beat.h_sync = (h_cnt >= CNT_W'(H_ACTIVE + H_FRONT)) &&
			(h_cnt < CNT_W'(H_ACTIVE + H_FRONT + H_SYNC)); // 840..967
		beat.v_sync = (v_cnt >= CNT_W'(V_ACTIVE + V_FRONT)) &&
			(v_cnt < CNT_W'(V_ACTIVE + V_FRONT + V_SYNC)); // 601..604
		beat.display_en = (h_cnt < CNT_W'(H_ACTIVE)) && (v_cnt < CNT_W'(V_ACTIVE));
	end

	a_h_range: assert property (@(posedge clk_in) disable iff (!arst_n)
		h_cnt < CNT_W'(H_TOTAL));

endmodule

`default_nettype wire

/* hdl/sprite_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

module sprite_fetch
	import video_pkg::*;
(
	input wire clk_in,
	input wire arst_n,
	input wire [3:0] scale_shift_x,
	input wire [3:0] scale_shift_y,
	input wire video_beat_t beat_in,
	output video_beat_t beat_out,
	output logic pixel_on
);

	// leftmost digit of a row lands in bit 0
	logic [0:IMG_W-1] bitmap [0:IMG_H-1];

	logic [CNT_W-1:0] col;
	logic [CNT_W-1:0] row;
	logic [IMG_COL_W-1:0] col_idx;
	logic [IMG_ROW_W-1:0] row_idx;
	logic in_bounds;
	logic pixel_bit;

	initial begin
		$readmemb(IMG_FILE, bitmap);
	end

	// power-of-two scaling
	assign col = beat_in.h_count >> scale_shift_x;
	assign row = beat_in.v_count >> scale_shift_y;

	assign in_bounds = (col < CNT_W'(IMG_W)) && (row < CNT_W'(IMG_H));
	assign col_idx = col[IMG_COL_W-1:0];
	assign row_idx = row[IMG_ROW_W-1:0];

	always_comb begin
		if (in_bounds) begin
			pixel_bit = bitmap[row_idx][col_idx];
		end else begin
			pixel_bit = 1'b0; // off the bitmap shows background
		end
	end

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			beat_out <= '0;
			pixel_on <= 1'b0;
		end else begin
			beat_out <= beat_in;
			pixel_on <= pixel_bit;
		end
	end

endmodule

`default_nettype wire

/* hdl/pixel_colorizer.sv */
`timescale 1ns/100ps
`default_nettype none

module pixel_colorizer
	import video_pkg::*;
(
	input wire clk_in,
	input wire arst_n,
	input wire [3*KEY_FIELD_W-1:0] key_colors,
	input wire video_beat_t beat_in,
	input wire pixel_on,
	output rgb_t rgb,
	output logic h_sync,
	output logic v_sync
);

	logic [KEY_FIELD_W-1:0] key_lo;
	logic [KEY_FIELD_W-1:0] key_mid;
	logic [KEY_FIELD_W-1:0] key_hi;
	rgb_t rgb_next;

	assign key_lo = key_colors[KEY_FIELD_W-1:0];
	assign key_mid = key_colors[2*KEY_FIELD_W-1:KEY_FIELD_W];
	assign key_hi = key_colors[3*KEY_FIELD_W-1:2*KEY_FIELD_W];

	// foreground and background swap red and blue fields
	always_comb begin
		rgb_next = '0;
		if (beat_in.display_en) begin
			rgb_next.g = COLOR_W'(key_mid);
			if (pixel_on) begin
				rgb_next.r = COLOR_W'(key_lo);
				rgb_next.b = COLOR_W'(key_hi);
			end else begin
				rgb_next.r = COLOR_W'(key_hi);
				rgb_next.b = COLOR_W'(key_lo);
			end
		end
	end

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			rgb <= '0;
			h_sync <= 1'b0;
			v_sync <= 1'b0;
		end else begin
			rgb <= rgb_next;
			h_sync <= beat_in.h_sync;
			v_sync <= beat_in.v_sync;
		end
	end

	// blanking holds one clock after display_en drops
	a_blank: assert property (@(posedge clk_in) disable iff (!arst_n)
		!$past(beat_in.display_en) |-> (rgb == '0));

endmodule

`default_nettype wire

/* hdl/pot_adc.sv */
`timescale 1ns/100ps
`default_nettype none

module pot_adc
	import adc_pkg::*;
(
	input wire clk_in,
	input wire arst_n,
	input wire pot_in,
	output logic pot_discharge,
	output logic [ADC_BITS-1:0] pot_value
);

	logic [ADC_DIV_W-1:0] div_cnt;
	logic tick;
	logic [ADC_BITS:0] tick_cnt; // extra msb is the phase
	logic captured;
	logic pot_meta;
	logic pot_sync;
	adc_phase_t phase;

	assign tick = (div_cnt == ADC_DIV_W'(ADC_DIV - 1));
	assign phase = adc_phase_t'(tick_cnt[ADC_BITS]);
	assign pot_discharge = (phase == DISCHARGE);

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			pot_meta <= 1'b0;
			pot_sync <= 1'b0;
		end else begin
			pot_meta <= pot_in;
			pot_sync <= pot_meta;
		end
	end

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			div_cnt <= '0;
			tick_cnt <= '0;
			captured <= 1'b0;
			pot_value <= '0;
		end else begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
			if (tick) begin
				tick_cnt <= tick_cnt + 1'b1;
				if (phase == CHARGE && !captured && pot_sync) begin
					pot_value <= tick_cnt[ADC_BITS-1:0]; // ticks since release
					captured <= 1'b1;
				end
				// last discharge tick, rearm for the next charge
				if (&tick_cnt) begin
					captured <= 1'b0;
				end
			end
		end
	end

	a_capture_phase: assert property (@(posedge clk_in) disable iff (!arst_n)
		(pot_value != $past(pot_value)) |-> ($past(phase) == CHARGE));

endmodule

`default_nettype wire

/* hdl/heart_display_top.sv */
`timescale 1ns/100ps
`default_nettype none

module heart_display_top
	import video_pkg::*, adc_pkg::*;
(
	input wire clk_in,
	input wire arst_n,
	input wire [8:0] key,
	input wire pot_in,
	output logic [COLOR_W-1:0] r_out,
	output logic [COLOR_W-1:0] g_out,
	output logic [COLOR_W-1:0] b_out,
	output logic h_sync,
	output logic v_sync,
	output logic pot_discharge,
	output logic [ADC_BITS-1:0] pot_value
);

	video_beat_t beat_t0;
	video_beat_t beat_t1;
	logic pixel_on;
	rgb_t rgb;

	video_timing u_timing (
		.clk_in (clk_in),
		.arst_n (arst_n),
		.beat   (beat_t0)
	);

	// keys are active low, so inverted keys give the shift
	sprite_fetch u_fetch (
		.clk_in        (clk_in),
		.arst_n        (arst_n),
		.scale_shift_x (~key[7:4]),
		.scale_shift_y (~key[3:0]),
		.beat_in       (beat_t0),
		.beat_out      (beat_t1),
		.pixel_on      (pixel_on)
	);

	pixel_colorizer u_color (
		.clk_in     (clk_in),
		.arst_n     (arst_n),
		.key_colors (key),
		.beat_in    (beat_t1),
		.pixel_on   (pixel_on),
		.rgb        (rgb),
		.h_sync     (h_sync),
		.v_sync     (v_sync)
	);

	assign r_out = rgb.r;
	assign g_out = rgb.g;
	assign b_out = rgb.b;

	pot_adc u_pot (
		.clk_in        (clk_in),
		.arst_n        (arst_n),
		.pot_in        (pot_in),
		.pot_discharge (pot_discharge),
		.pot_value     (pot_value)
	);

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 40
) (
	output logic clk
);

	initial clk = 1'b0;

	always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

/* bench/tb_heart_display.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_heart_display
	import video_pkg::*, adc_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int FRAME_CLKS = H_TOTAL * V_TOTAL;
	localparam int VIS_LINE0 = V_SYNC + V_BACK; // lines from v_sync rise to first visible
	localparam int WAIT_FRAME = FRAME_CLKS + 10000;
	localparam int WAIT_POT = (2 ** ADC_BITS) * ADC_DIV + 1000;
	localparam int POT_D1 = 400;
	localparam int POT_D2 = 1000;

	logic clk_in;
	logic arst_n;
	logic [8:0] key;
	logic pot_in;
	logic [COLOR_W-1:0] r_out;
	logic [COLOR_W-1:0] g_out;
	logic [COLOR_W-1:0] b_out;
	logic h_sync;
	logic v_sync;
	logic pot_discharge;
	logic [ADC_BITS-1:0] pot_value;
	logic [11:0] rgb_now;

	int seed;
	int reset_errors;
	int sync_errors;
	int pixel_errors;
	int pot_errors;
	bit timeout_hit;
	bit check_pixels;
	int pot_delay;

	// monitor state updated on the falling edge
	logic hs_q;
	logic vs_q;
	bit hs_seen;
	bit vs_seen;
	int hpos;
	int fpos;
	bit blank_zone;

	logic [IMG_W-1:0] ref_img [0:IMG_H-1]; // msb is the leftmost pixel

	assign rgb_now = {r_out, g_out, b_out};

	tb_clock #(.PERIOD(CLK_PERIOD)) u_clock (.clk(clk_in));

	heart_display_top DUT (
		.clk_in        (clk_in),
		.arst_n        (arst_n),
		.key           (key),
		.pot_in        (pot_in),
		.r_out         (r_out),
		.g_out         (g_out),
		.b_out         (b_out),
		.h_sync        (h_sync),
		.v_sync        (v_sync),
		.pot_discharge (pot_discharge),
		.pot_value     (pot_value)
	);

	initial $readmemb("hdl/heart_bitmap.mem", ref_img);

	function automatic logic [11:0] colour_of(input int x, input int y, input logic [8:0] k);
		logic [3:0] sx;
		logic [3:0] sy;
		int col;
		int row;
		logic on;
		sx = ~k[7:4];
		sy = ~k[3:0];
		col = x >> sx;
		row = y >> sy;
		on = 1'b0;
		if (col < IMG_W && row < IMG_H)
			on = ref_img[row][IMG_W-1-col];
		if (on)
			return {1'b0, k[2:0], 1'b0, k[5:3], 1'b0, k[8:6]};
		else
			return {1'b0, k[8:6], 1'b0, k[5:3], 1'b0, k[2:0]};
	endfunction

	// pot pin rises pot_delay clocks after release
	initial begin
		int pot_cnt;
		logic held_low;
		pot_in = 1'b0;
		pot_cnt = 0;
		held_low = 1'b1;
		forever begin
			@(negedge clk_in);
			held_low = pot_discharge || !arst_n;
			@(posedge clk_in);
			#2;
			if (held_low) begin
				pot_cnt = 0;
				pot_in = 1'b0;
			end else if (pot_cnt >= pot_delay) begin
				pot_in = 1'b1;
			end else begin
				pot_cnt = pot_cnt + 1;
			end
		end
	end

	always @(negedge clk_in) begin : monitor
		int line;
		int h;
		logic [11:0] want;
		if (!arst_n) begin
			hs_q = 1'b0;
			vs_q = 1'b0;
			hs_seen = 1'b0;
			vs_seen = 1'b0;
			hpos = 0;
			fpos = 0;
			blank_zone = 1'b0;
		end else begin
			if (h_sync && !hs_q) begin
				if (hs_seen)
					assert (hpos + 1 == H_TOTAL) else begin
						sync_errors++;
						$display("[ERROR] h_sync period 0x%0h expected 0x%0h", hpos + 1, H_TOTAL);
					end
				hs_seen = 1'b1;
				hpos = 0;
			end else begin
				if (!h_sync && hs_q)
					assert (hpos + 1 == H_SYNC) else begin
						sync_errors++;
						$display("[ERROR] h_sync width 0x%0h expected 0x%0h", hpos + 1, H_SYNC);
					end
				hpos = hpos + 1;
			end
			if (v_sync && !vs_q) begin
				if (vs_seen)
					assert (fpos + 1 == FRAME_CLKS) else begin
						sync_errors++;
						$display("[ERROR] v_sync period 0x%0h expected 0x%0h", fpos + 1, FRAME_CLKS);
					end
				// v_sync starts a line, so it sits H_SYNC+H_BACK after h_sync rise
				assert (hpos == H_SYNC + H_BACK) else begin
					sync_errors++;
					$display("[ERROR] h_sync to v_sync 0x%0h expected 0x%0h", hpos, H_SYNC + H_BACK);
				end
				vs_seen = 1'b1;
				fpos = 0;
			end else begin
				if (!v_sync && vs_q)
					assert (fpos + 1 == V_SYNC * H_TOTAL) else begin
						sync_errors++;
						$display("[ERROR] v_sync width 0x%0h expected 0x%0h", fpos + 1,
							V_SYNC * H_TOTAL);
					end
				fpos = fpos + 1;
			end
			line = fpos / H_TOTAL;
			h = fpos % H_TOTAL;
			blank_zone = vs_seen && !(line >= VIS_LINE0 && line < VIS_LINE0 + V_ACTIVE &&
				h < H_ACTIVE);
			if (vs_seen && check_pixels && !blank_zone) begin
				want = colour_of(h, line - VIS_LINE0, key);
				assert (rgb_now == want) else begin
					pixel_errors++;
					$display("[ERROR] rgb at x %0d y %0d 0x%03h expected 0x%03h", h,
						line - VIS_LINE0, rgb_now, want);
				end
			end
			hs_q = h_sync;
			vs_q = v_sync;
		end
	end

	a_blank: assert property (@(posedge clk_in) disable iff (!arst_n)
		blank_zone |-> (rgb_now == 12'h000))
		else begin
			pixel_errors++;
			$display("[ERROR] rgb 0x%03h expected 0x000 in blanking", $sampled(rgb_now));
		end

	task automatic wait_vsync_rise();
		int n;
		logic prev;
		n = 0;
		if (timeout_hit)
			return;
		prev = v_sync;
		while (n < WAIT_FRAME) begin
			@(negedge clk_in);
			if (v_sync && !prev)
				break;
			prev = v_sync;
			n++;
		end
		if (n >= WAIT_FRAME) begin
			timeout_hit = 1'b1;
			$display("timeout while waiting for v_sync to rise");
		end
	endtask

	task automatic wait_pot_level(input logic level);
		int n;
		n = 0;
		if (timeout_hit)
			return;
		while (n < WAIT_POT) begin
			@(negedge clk_in);
			if (pot_discharge == level)
				break;
			n++;
		end
		if (n >= WAIT_POT) begin
			timeout_hit = 1'b1;
			$display("timeout while waiting for pot_discharge to go %0d", level);
		end
	endtask

	task automatic drive_key(input logic [8:0] k);
		@(posedge clk_in);
		#2;
		key = k;
	endtask

	task automatic check_reset(input string name, input logic [15:0] value);
		assert (value == 16'h0) else begin
			reset_errors++;
			$display("[ERROR] %s 0x%0h expected 0x0 after reset", name, value);
		end
	endtask

	task automatic check_pot(input int d);
		int want;
		int diff;
		if (timeout_hit)
			return;
		want = d / ADC_DIV;
		diff = int'(pot_value) - want;
		if (diff < 0)
			diff = -diff;
		assert (diff <= 1) else begin
			pot_errors++;
			$display("[ERROR] pot_value 0x%0h expected 0x%0h within one", pot_value, want);
		end
	endtask

	initial begin
		logic [31:0] rnd;
		seed = 32'h0c04f647;
		key = 9'h1ff;
		arst_n = 1'b0;
		reset_errors = 0;
		sync_errors = 0;
		pixel_errors = 0;
		pot_errors = 0;
		timeout_hit = 1'b0;
		check_pixels = 1'b0;
		pot_delay = POT_D1;
		repeat (2) @(posedge clk_in);
		#2;
		arst_n = 1'b1;
		@(negedge clk_in);
		check_reset("rgb", {4'h0, rgb_now});
		check_reset("h_sync", {15'h0, h_sync});
		check_reset("v_sync", {15'h0, v_sync});
		check_reset("pot_discharge", {15'h0, pot_discharge});
		check_reset("pot_value", {1'b0, pot_value});
		fork
			begin
				wait_vsync_rise();
				rnd = $random(seed);
				rnd[7:0] = 8'hdd; // shift 2 on both axes so the bitmap fills 160x120
				drive_key(rnd[8:0]);
				check_pixels = 1'b1;
				wait_vsync_rise();
				rnd = $random(seed);
				drive_key(rnd[8:0]);
				wait_vsync_rise();
				check_pixels = 1'b0;
			end
			begin
				wait_pot_level(1'b1);
				check_pot(POT_D1);
				@(posedge clk_in);
				#2;
				pot_delay = POT_D2;
				wait_pot_level(1'b0);
				wait_pot_level(1'b1);
				check_pot(POT_D2);
			end
		join
		$display("errors: reset %0d, sync %0d, pixel %0d, pot %0d, timeout %0d",
			reset_errors, sync_errors, pixel_errors, pot_errors, timeout_hit);
		if (timeout_hit || reset_errors + sync_errors + pixel_errors + pot_errors != 0)
			$display("Simulation finished: FAIL");
		else
			$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
hdl/video_pkg.sv
hdl/adc_pkg.sv
hdl/video_timing.sv
hdl/sprite_fetch.sv
hdl/pixel_colorizer.sv
hdl/pot_adc.sv
hdl/heart_display_top.sv
bench/tb_clock.sv
bench/tb_heart_display.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f project.f \
	--top-module tb_heart_display \
	-Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see sim.log"
	exit 1
fi

if grep -q "Simulation finished: FAIL" sim.log; then
	echo "testbench reported failure, see sim.log"
	exit 1
fi

if ! grep -q "Simulation finished: PASS" sim.log; then
	echo "no result line in sim.log"
	exit 1
fi

echo "simulation passed"
exit 0

/* hdl/heart_bitmap.mem */
// 30 rows of 40 pixels, leftmost digit is column 0, 1 is foreground
0000000000000000000000000000000000000000
0000000000000000000000000000000000000000
0000000011111111000000001111111100000000
0000001111111111110000111111111111000000
0000011100111111111001111111111111100000
0000111100111111111111111111111111110000
0001111111111111111111111111111111111000
0001111111111111111111111111111111111000
0001111111111111111111111111111111111000
0001111111111111111111111111111111111000
0000111111111111111111111111111111110000
0000111111111111111111111111111111110000
0000011111111111111111111111111111100000
0000001111111111111111111111111111000000
0000000111111111111111111111111110000000
0000000011111111111111111111111100000000
0000000001111111111111111111111000000000
0000000000111111111111111111110000000000
0000000000011111111111111111100000000000
0000000000001111111111111111000000000000
0000000000000111111111111110000000000000
0000000000000011111111111100000000000000
0000000000000001111111111000000000000000
0000000000000000111111110000000000000000
0000000000000000011111100000000000000000
0000000000000000001111000000000000000000
0000000000000000000110000000000000000000
0000000000000000000000000000000000000000
0000000000000000000000000000000000000000
0000000000000000000000000000000000000000
